// ==== build.f ====
rf_pkg.sv
wr_predecoder.sv
wr_word_decoder.sv
wr_port_arbiter.sv
rf_storage_array.sv
rd_mux_pipe.sv
rf_top.sv
rf_checker.sv
tb_rf_top.sv

// ==== Bender.yml ====
package:
  name: rf_top

sources:
  - rf_pkg.sv
  - wr_predecoder.sv
  - wr_word_decoder.sv
  - wr_port_arbiter.sv
  - rf_storage_array.sv
  - rd_mux_pipe.sv
  - rf_top.sv
  - target: test
    files:
      - rf_checker.sv
      - tb_rf_top.sv

// ==== tb_rf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rf_top;

  import rf_pkg::*;

  localparam int DW           = DEF_DATA_WIDTH;
  localparam int AB           = DEF_ADDR_BITS;
  localparam int NWR          = DEF_NUM_WR_PORTS;
  localparam int NRD          = DEF_NUM_RD_PORTS;
  localparam int NUM_ROWS     = 1 << AB;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int DUAL_N       = 24;
  localparam int COLL_N       = 8;
  localparam int RAND_N       = 400;
  // stimulus cycles of all tests together
  localparam int TOTAL_CYCLES =
    RESET_CYCLES + 5 + 2*NUM_ROWS + 2*DUAL_N + 2*COLL_N + RAND_N;

  logic                clk;
  logic                rst;
  logic [NWR-1:0]      wr_en;
  logic [NWR*AB-1:0]   wr_addr;
  logic [NWR*DW-1:0]   wr_data;
  logic [NRD-1:0]      rd_en;
  logic [NRD*AB-1:0]   rd_addr;
  logic [NRD-1:0]      rd_vld;
  logic [NRD*DW-1:0]   rd_data;

  int err_count;
  int pending;
  int seed;
  int test_count;
  int tb_errs;
  int start_errs;
  int total;

  always #(CLK_PERIOD/2) clk = ~clk;

  rf_top i_rf_top (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_vld  (rd_vld),
    .rd_data (rd_data)
  );

  rf_checker #(
    .DATA_WIDTH   (DW),
    .ADDR_BITS    (AB),
    .NUM_WR_PORTS (NWR),
    .NUM_RD_PORTS (NRD),
    .READ_DELAY   (DEF_READ_DELAY)
  ) i_rf_checker (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_vld    (rd_vld),
    .rd_data   (rd_data),
    .err_count (err_count),
    .pending   (pending)
  );

  //////////////////////////////////////////////////////////////////////
  // drive helpers
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic set_idle();
    wr_en = '0;
    rd_en = '0;
  endtask

  task automatic write_port(input int p, input logic [AB-1:0] addr, input logic [DW-1:0] data);
    wr_en[p] = 1'b1;
    wr_addr[p*AB +: AB] = addr;
    wr_data[p*DW +: DW] = data;
  endtask

  task automatic read_port(input int r, input logic [AB-1:0] addr);
    rd_en[r] = 1'b1;
    rd_addr[r*AB +: AB] = addr;
  endtask

  // odd multiplier keeps every row's word distinct
  function automatic logic [DW-1:0] fill_word(input int a);
    return DW'((a * 37) ^ 'h5a);
  endfunction

  // drain outstanding reads, then report the test
  task automatic finish_test(input string name);
    int waited;
    int errs;
    set_idle();
    next_cycle();
    waited = 0;
    while (pending != 0 && waited < 4*DEF_READ_DELAY + 8) begin
      next_cycle();
      waited++;
    end
    if (pending != 0) begin
      $display("test %s: reads still outstanding after the drain", name);
      tb_errs++;
    end
    errs = err_count + tb_errs - start_errs;
    $display("test %-12s %0d errors", name, errs);
    test_count++;
    start_errs = err_count + tb_errs;
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic fill_and_read();
    for (int a = 0; a < NUM_ROWS; a++) begin
      set_idle();
      write_port(0, AB'(a), fill_word(a));
      next_cycle();
    end
    for (int a = 0; a < NUM_ROWS; a++) begin
      set_idle();
      read_port(0, AB'(a));
      read_port(1, AB'(NUM_ROWS - 1 - a));
      next_cycle();
    end
  endtask

  task automatic dual_write();
    logic [AB-1:0] a0;
    logic [AB-1:0] a1;
    for (int i = 0; i < DUAL_N; i++) begin
      a0 = AB'($random(seed));
      a1 = AB'($random(seed));
      if (a1 == a0) begin
        a1 = a0 + 1'b1;
      end
      set_idle();
      write_port(0, a0, DW'($random(seed)));
      write_port(1, a1, DW'($random(seed)));
      next_cycle();
      set_idle();
      read_port(0, a0);
      read_port(1, a1);
      next_cycle();
    end
  endtask

  task automatic same_row_write();
    logic [AB-1:0] a;
    logic [DW-1:0] d0;
    for (int i = 0; i < COLL_N; i++) begin
      a  = AB'($random(seed));
      d0 = DW'($random(seed));
      set_idle();
      write_port(0, a, d0);
      write_port(1, a, d0 + DW'(1 + ($random(seed) & 'h3f)));
      next_cycle();
      set_idle();
      read_port(0, a);
      read_port(1, a);
      next_cycle();
    end
  endtask

  // small address window so reads often hit rows written nearby
  task automatic random_traffic();
    for (int i = 0; i < RAND_N; i++) begin
      set_idle();
      for (int p = 0; p < NWR; p++) begin
        if ($random(seed) & 1) begin
          write_port(p, AB'($random(seed) & 'hf), DW'($random(seed)));
        end
      end
      if (wr_en[0] && ($random(seed) & 1)) begin
        read_port(0, wr_addr[AB-1:0]);
      end else begin
        read_port(0, AB'($random(seed) & 'hf));
      end
      read_port(1, AB'($random(seed) & 'hf));
      next_cycle();
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    wr_en      = '0;
    wr_addr    = '0;
    wr_data    = '0;
    rd_en      = '0;
    rd_addr    = '0;
    seed       = 32'h2e4a_d100;
    test_count = 0;
    tb_errs    = 0;
    start_errs = 0;

    repeat (RESET_CYCLES) next_cycle();
    rst = 1'b0;
    repeat (5) next_cycle();
    finish_test("reset");

    fill_and_read();
    finish_test("fill_read");
    dual_write();
    finish_test("dual_write");
    same_row_write();
    finish_test("same_row");
    random_traffic();
    finish_test("random");

    total = err_count + tb_errs;
    $display("%0d tests run, %0d errors", test_count, total);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((TOTAL_CYCLES + 100) * CLK_PERIOD);
    $display("timeout: the tests did not finish in the expected time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rf_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_checker #(
  parameter int DATA_WIDTH   = rf_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_BITS    = rf_pkg::DEF_ADDR_BITS,
  parameter int NUM_WR_PORTS = rf_pkg::DEF_NUM_WR_PORTS,
  parameter int NUM_RD_PORTS = rf_pkg::DEF_NUM_RD_PORTS,
  parameter int READ_DELAY   = rf_pkg::DEF_READ_DELAY
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [NUM_WR_PORTS-1:0]            wr_en,
  input  logic [NUM_WR_PORTS*ADDR_BITS-1:0]  wr_addr,
  input  logic [NUM_WR_PORTS*DATA_WIDTH-1:0] wr_data,
  input  logic [NUM_RD_PORTS-1:0]            rd_en,
  input  logic [NUM_RD_PORTS*ADDR_BITS-1:0]  rd_addr,
  input  logic [NUM_RD_PORTS-1:0]            rd_vld,
  input  logic [NUM_RD_PORTS*DATA_WIDTH-1:0] rd_data,
  output int                                 err_count,
  output int                                 pending
);

  localparam int NUM_ROWS   = 1 << ADDR_BITS;
  localparam int FIFO_DEPTH = 16;

  // shadow copy of the storage array
  logic [DATA_WIDTH-1:0] shadow  [NUM_ROWS];
  bit                    written [NUM_ROWS];

  // outstanding reads, one ring per read port
  logic [DATA_WIDTH-1:0] exp_data  [NUM_RD_PORTS][FIFO_DEPTH];
  logic [ADDR_BITS-1:0]  exp_addr  [NUM_RD_PORTS][FIFO_DEPTH];
  bit                    exp_known [NUM_RD_PORTS][FIFO_DEPTH];
  int                    exp_cycle [NUM_RD_PORTS][FIFO_DEPTH];
  int                    head      [NUM_RD_PORTS];
  int                    count     [NUM_RD_PORTS];
  int                    cycle;
  bit                    started;

  initial begin
    err_count = 0;
    pending   = 0;
    cycle     = 0;
    started   = 1'b0;
  end

  // row contents as they stood before this edge's writes
  function automatic logic [DATA_WIDTH-1:0] expected_word(input logic [ADDR_BITS-1:0] addr);
    return shadow[addr];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare, queue new reads, then apply writes
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : check_edge
    bit                    due;
    int                    slot;
    int                    total;
    logic [ADDR_BITS-1:0]  addr;
    logic [DATA_WIDTH-1:0] got;

    if (started) begin
      for (int r = 0; r < NUM_RD_PORTS; r++) begin
        slot = head[r];
        due  = (count[r] > 0) && (exp_cycle[r][slot] + READ_DELAY == cycle);
        got  = rd_data[r*DATA_WIDTH +: DATA_WIDTH];
        if (rd_vld[r] !== due) begin
          if (due) begin
            $display("read port %0d: rd_vld did not arrive at %0t for the read of cycle %0d",
                     r, $time, exp_cycle[r][slot]);
          end else begin
            $display("read port %0d: rd_vld high at %0t with no read outstanding", r, $time);
          end
          err_count++;
        end
        if (due) begin
          // never written rows hold no defined value
          if (rd_vld[r] === 1'b1 && exp_known[r][slot] && got !== exp_data[r][slot]) begin
            $display("CHECK FAILED at %0t: read port %0d addr %0h got %0h expected %0h",
                     $time, r, exp_addr[r][slot], got, exp_data[r][slot]);
            err_count++;
          end
          head[r]  = (head[r] + 1) % FIFO_DEPTH;
          count[r] = count[r] - 1;
        end
      end
    end

    if (!rst) begin
      for (int r = 0; r < NUM_RD_PORTS; r++) begin
        if (rd_en[r]) begin
          if (count[r] == FIFO_DEPTH) begin
            $display("read port %0d: too many reads outstanding at %0t", r, $time);
            err_count++;
          end else begin
            addr = rd_addr[r*ADDR_BITS +: ADDR_BITS];
            slot = (head[r] + count[r]) % FIFO_DEPTH;
            exp_data[r][slot]  = expected_word(addr);
            exp_addr[r][slot]  = addr;
            exp_known[r][slot] = written[addr];
            exp_cycle[r][slot] = cycle;
            count[r] = count[r] + 1;
          end
        end
      end
    end

    // ascending port order, so the highest port on a row wins
    for (int p = 0; p < NUM_WR_PORTS; p++) begin
      if (wr_en[p]) begin
        addr = wr_addr[p*ADDR_BITS +: ADDR_BITS];
        shadow[addr]  = wr_data[p*DATA_WIDTH +: DATA_WIDTH];
        written[addr] = 1'b1;
      end
    end

    total = 0;
    for (int r = 0; r < NUM_RD_PORTS; r++) begin
      total += count[r];
    end
    pending = total;
    // outputs are undefined before the first reset edge
    if (rst) begin
      started = 1'b1;
    end
    cycle++;
  end

endmodule

`default_nettype wire

// ==== rf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_top #(
  parameter int DATA_WIDTH   = rf_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_BITS    = rf_pkg::DEF_ADDR_BITS,
  parameter int NUM_WR_PORTS = rf_pkg::DEF_NUM_WR_PORTS,
  parameter int NUM_RD_PORTS = rf_pkg::DEF_NUM_RD_PORTS,
  parameter int PRED_BITS    = rf_pkg::DEF_PRED_BITS,
  parameter int READ_DELAY   = rf_pkg::DEF_READ_DELAY
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [NUM_WR_PORTS-1:0]            wr_en,
  input  logic [NUM_WR_PORTS*ADDR_BITS-1:0]  wr_addr,
  input  logic [NUM_WR_PORTS*DATA_WIDTH-1:0] wr_data,
  input  logic [NUM_RD_PORTS-1:0]            rd_en,
  input  logic [NUM_RD_PORTS*ADDR_BITS-1:0]  rd_addr,
  output logic [NUM_RD_PORTS-1:0]            rd_vld,
  output logic [NUM_RD_PORTS*DATA_WIDTH-1:0] rd_data
);

  import rf_pkg::*;

  localparam int NUM_ROWS = 1 << ADDR_BITS;
  localparam int IDX_BITS = port_idx_bits(NUM_WR_PORTS);

  logic [NUM_WR_PORTS*NUM_ROWS-1:0] word_lines_all;
  logic [NUM_ROWS-1:0]              row_load;
  logic [NUM_ROWS*IDX_BITS-1:0]     row_port;
  logic [NUM_ROWS*DATA_WIDTH-1:0]   mem_rows;

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NUM_WR_PORTS; p++) begin : g_wr
    wr_word_decoder #(
      .ADDR_BITS (ADDR_BITS),
      .PRED_BITS (PRED_BITS)
    ) i_wr_word_decoder (
      .wr_en      (wr_en[p]),
      .wr_addr    (wr_addr[p*ADDR_BITS +: ADDR_BITS]),
      .word_lines (word_lines_all[p*NUM_ROWS +: NUM_ROWS])
    );
  end

  wr_port_arbiter #(
    .ADDR_BITS    (ADDR_BITS),
    .NUM_WR_PORTS (NUM_WR_PORTS)
  ) i_wr_port_arbiter (
    .word_lines_all (word_lines_all),
    .row_load       (row_load),
    .row_port       (row_port)
  );

  rf_storage_array #(
    .DATA_WIDTH   (DATA_WIDTH),
    .ADDR_BITS    (ADDR_BITS),
    .NUM_WR_PORTS (NUM_WR_PORTS)
  ) i_rf_storage_array (
    .clk         (clk),
    .wr_data_all (wr_data),
    .row_load    (row_load),
    .row_port    (row_port),
    .mem_rows    (mem_rows)
  );

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < NUM_RD_PORTS; r++) begin : g_rd
    rd_mux_pipe #(
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_BITS  (ADDR_BITS),
      .READ_DELAY (READ_DELAY)
    ) i_rd_mux_pipe (
      .clk      (clk),
      .rst      (rst),
      .mem_rows (mem_rows),
      .rd_en    (rd_en[r]),
      .rd_addr  (rd_addr[r*ADDR_BITS +: ADDR_BITS]),
      .rd_vld   (rd_vld[r]),
      .rd_data  (rd_data[r*DATA_WIDTH +: DATA_WIDTH])
    );
  end

endmodule

`default_nettype wire

// ==== rd_mux_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module rd_mux_pipe #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_BITS  = 6,
  parameter int READ_DELAY = 2
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [(1 << ADDR_BITS)*DATA_WIDTH-1:0] mem_rows,
  input  logic                                  rd_en,
  input  logic [ADDR_BITS-1:0]                  rd_addr,
  output logic                                  rd_vld,
  output logic [DATA_WIDTH-1:0]                 rd_data
);

  localparam int NUM_ROWS = 1 << ADDR_BITS;
  localparam int ALL_W    = NUM_ROWS * DATA_WIDTH;

  if (READ_DELAY < 1 || READ_DELAY > ADDR_BITS) begin : g_bad_delay
    $error("READ_DELAY %0d outside 1..%0d", READ_DELAY, ADDR_BITS);
  end

  // level i input, narrower levels use the low words only
  logic [ALL_W-1:0]     lvl_words [ADDR_BITS+1];
  logic [ADDR_BITS-1:0] lvl_addr  [ADDR_BITS];
  logic [ADDR_BITS:0]   lvl_vld;

  assign lvl_words[0] = mem_rows;
  assign lvl_addr[0]  = rd_addr;
  assign lvl_vld[0]   = rd_en;

  //////////////////////////////////////////////////////////////////////
  // mux tree, one level per address bit
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < ADDR_BITS; i++) begin : g_lvl
    localparam int OUT_WORDS = NUM_ROWS >> (i + 1);

    logic [OUT_WORDS*DATA_WIDTH-1:0] mux_out;

    for (genvar k = 0; k < OUT_WORDS; k++) begin : g_mux
      assign mux_out[k*DATA_WIDTH +: DATA_WIDTH] = lvl_addr[i][i] ?
        lvl_words[i][(2*k+1)*DATA_WIDTH +: DATA_WIDTH] :
        lvl_words[i][(2*k)*DATA_WIDTH +: DATA_WIDTH];
    end

    // stages after the first READ_DELAY-1 levels and at the output
    if (i <= READ_DELAY - 2 || i == ADDR_BITS - 1) begin : g_reg
      logic [OUT_WORDS*DATA_WIDTH-1:0] words_q;
      logic                            vld_q;

      always_ff @(posedge clk) begin
        words_q <= mux_out;
      end

      always_ff @(posedge clk) begin
        if (rst) begin
          vld_q <= 1'b0;
        end else begin
          vld_q <= lvl_vld[i];
        end
      end

      assign lvl_words[i+1] = ALL_W'(words_q);
      assign lvl_vld[i+1]   = vld_q;

      // upper address bits still needed by later levels
      if (i < ADDR_BITS - 1) begin : g_addr
        logic [ADDR_BITS-1:0] addr_q;

        always_ff @(posedge clk) begin
          addr_q <= lvl_addr[i];
        end

        assign lvl_addr[i+1] = addr_q;
      end
    end else begin : g_comb
      assign lvl_words[i+1] = ALL_W'(mux_out);
      assign lvl_vld[i+1]   = lvl_vld[i];
      assign lvl_addr[i+1]  = lvl_addr[i];
    end
  end

  assign rd_data = lvl_words[ADDR_BITS][DATA_WIDTH-1:0];
  assign rd_vld  = lvl_vld[ADDR_BITS];

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_addr_known: assert property (@(posedge clk) disable iff (rst)
    rd_en |-> !$isunknown(rd_addr))
    else $error("rd_addr has unknown bits while rd_en is high");

endmodule

`default_nettype wire

// ==== rf_storage_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_storage_array #(
  parameter int DATA_WIDTH   = 8,
  parameter int ADDR_BITS    = 6,
  parameter int NUM_WR_PORTS = 2
) (
  input  logic                                                             clk,
  input  logic [NUM_WR_PORTS*DATA_WIDTH-1:0]                               wr_data_all,
  input  logic [(1 << ADDR_BITS)-1:0]                                      row_load,
  input  logic [(1 << ADDR_BITS)*rf_pkg::port_idx_bits(NUM_WR_PORTS)-1:0]  row_port,
  output logic [(1 << ADDR_BITS)*DATA_WIDTH-1:0]                           mem_rows
);

  import rf_pkg::*;

  localparam int NUM_ROWS = 1 << ADDR_BITS;
  localparam int IDX_BITS = port_idx_bits(NUM_WR_PORTS);

  //////////////////////////////////////////////////////////////////////
  // one register per row
  //////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < NUM_ROWS; r++) begin : g_row
    logic [IDX_BITS-1:0]   sel;
    logic [DATA_WIDTH-1:0] row_d;
    logic [DATA_WIDTH-1:0] row_q;

    assign sel   = row_port[r*IDX_BITS +: IDX_BITS];
    // write data mux for this row
    assign row_d = wr_data_all[sel*DATA_WIDTH +: DATA_WIDTH];

    always_ff @(posedge clk) begin
      if (row_load[r]) begin
        row_q <= row_d;
      end
    end

    assign mem_rows[r*DATA_WIDTH +: DATA_WIDTH] = row_q;
  end

endmodule

`default_nettype wire

// ==== wr_port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_port_arbiter #(
  parameter int ADDR_BITS    = 6,
  parameter int NUM_WR_PORTS = 2
) (
  input  logic [NUM_WR_PORTS*(1 << ADDR_BITS)-1:0]                         word_lines_all,
  output logic [(1 << ADDR_BITS)-1:0]                                      row_load,
  output logic [(1 << ADDR_BITS)*rf_pkg::port_idx_bits(NUM_WR_PORTS)-1:0]  row_port
);

  import rf_pkg::*;

  localparam int NUM_ROWS = 1 << ADDR_BITS;
  localparam int IDX_BITS = port_idx_bits(NUM_WR_PORTS);

  // ascending scan, so the highest port on a row wins
  always_comb begin
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_load[r] = 1'b0;
      row_port[r*IDX_BITS +: IDX_BITS] = '0;
      for (int p = 0; p < NUM_WR_PORTS; p++) begin
        if (word_lines_all[p*NUM_ROWS + r]) begin
          row_load[r] = 1'b1;
          row_port[r*IDX_BITS +: IDX_BITS] = IDX_BITS'(p);
        end
      end
    end
  end

  // the port named for a loaded row really addresses that row
  for (genvar r = 0; r < NUM_ROWS; r++) begin : g_chk
    always_comb begin
      if (row_load[r] === 1'b1) begin
        assert final (word_lines_all[row_port[r*IDX_BITS +: IDX_BITS]*NUM_ROWS + r])
          else $error("row %0d loads from a port that does not write it", r);
      end
    end
  end

endmodule

`default_nettype wire

// ==== wr_word_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_word_decoder #(
  parameter int ADDR_BITS = 6,
  parameter int PRED_BITS = 2
) (
  input  logic                        wr_en,
  input  logic [ADDR_BITS-1:0]        wr_addr,
  output logic [(1 << ADDR_BITS)-1:0] word_lines
);

  import rf_pkg::*;

  localparam int NUM_ROWS    = 1 << ADDR_BITS;
  localparam int NUM_PRED    = num_pred_lines(ADDR_BITS, PRED_BITS);
  localparam int GROUP_LINES = 1 << PRED_BITS;
  localparam int NUM_GROUPS  = (ADDR_BITS + PRED_BITS - 1) / PRED_BITS;

  logic [NUM_PRED-1:0] pred_lines;

  wr_predecoder #(
    .ADDR_BITS (ADDR_BITS),
    .PRED_BITS (PRED_BITS)
  ) i_wr_predecoder (
    .addr       (wr_addr),
    .pred_lines (pred_lines)
  );

  //////////////////////////////////////////////////////////////////////
  // row lines
  //////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < NUM_ROWS; r++) begin : g_row
    logic [NUM_GROUPS-1:0] hits;

    // pick the line of each group that matches this row number
    for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_grp
      assign hits[g] =
        pred_lines[g*GROUP_LINES + ((r >> (g*PRED_BITS)) % GROUP_LINES)];
    end

    assign word_lines[r] = wr_en & (&hits);
  end

  // predecoder and row AND plane together select exactly one row
  always_comb begin
    if (!$isunknown(wr_en)) begin
      assert final (wr_en ? $onehot(word_lines) : (word_lines == '0))
        else $error("word lines not one-hot for wr_addr %0h", wr_addr);
    end
  end

endmodule

`default_nettype wire

// ==== wr_predecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_predecoder #(
  parameter int ADDR_BITS = 6,
  parameter int PRED_BITS = 2
) (
  input  logic [ADDR_BITS-1:0]                                      addr,
  output logic [rf_pkg::num_pred_lines(ADDR_BITS, PRED_BITS)-1:0]   pred_lines
);

  import rf_pkg::*;

  localparam int NUM_PRED    = num_pred_lines(ADDR_BITS, PRED_BITS);
  localparam int NUM_FULL    = ADDR_BITS / PRED_BITS;
  localparam int REM_BITS    = ADDR_BITS % PRED_BITS;
  localparam int GROUP_LINES = 1 << PRED_BITS;

  // full groups, lowest address bits first
  for (genvar g = 0; g < NUM_FULL; g++) begin : g_full
    assign pred_lines[g*GROUP_LINES +: GROUP_LINES] =
      GROUP_LINES'(1) << addr[g*PRED_BITS +: PRED_BITS];
  end

  // short group from the top address bits
  if (REM_BITS != 0) begin : g_rem
    localparam int REM_LINES = 1 << REM_BITS;

    assign pred_lines[NUM_PRED-1 -: REM_LINES] =
      REM_LINES'(1) << addr[ADDR_BITS-1 -: REM_BITS];
  end

endmodule

`default_nettype wire

// ==== rf_pkg.sv ====
`default_nettype none

package rf_pkg;

  //////////////////////////////////////////////////////////////////////
  // default sizes
  //////////////////////////////////////////////////////////////////////

  localparam int DEF_DATA_WIDTH   = 8;
  localparam int DEF_ADDR_BITS    = 6;
  localparam int DEF_NUM_WR_PORTS = 2;
  localparam int DEF_NUM_RD_PORTS = 2;
  localparam int DEF_PRED_BITS    = 2;
  // legal range is 1 to ADDR_BITS
  localparam int DEF_READ_DELAY   = 2;

  //////////////////////////////////////////////////////////////////////
  // derived widths
  //////////////////////////////////////////////////////////////////////

  // full groups give 2**pred_bits lines, a short last group 2**rem
  function automatic int num_pred_lines(input int addr_bits, input int pred_bits);
    int full_groups;
    int rem_bits;
    full_groups = addr_bits / pred_bits;
    rem_bits    = addr_bits % pred_bits;
    num_pred_lines = full_groups * (1 << pred_bits);
    if (rem_bits != 0) begin
      num_pred_lines += (1 << rem_bits);
    end
  endfunction

  // a single port still gets a one bit index
  function automatic int port_idx_bits(input int num_ports);
    return (num_ports > 1) ? $clog2(num_ports) : 1;
  endfunction

endpackage

`default_nettype wire
